// ==== mem_cursor.sv ====
module mem_cursor (
    input  logic             clk,
    input  logic             nrst,
    input  logic             activate_rand,
    input  logic             strobe,
    input  mem_pkg::button_t button,
    output mem_pkg::pos_t    mem_pos
);
    import mem_pkg::*;

    pos_t nxt_pos;  // position after this cycle's press

    always_comb begin
        nxt_pos = mem_pos;
        if (strobe) begin
            case (button)
                btn_right: nxt_pos = mem_pos + 2'd1;    // wraps 3 -> 0
                btn_left:  nxt_pos = mem_pos - 2'd1;    // wraps 0 -> 3
                default:   nxt_pos = mem_pos;           // up, down, select, back leave it
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            mem_pos <= '0;
        end else if (activate_rand) begin
            mem_pos <= '0;          // new round starts at the leftmost button
        end else begin
            mem_pos <= nxt_pos;
        end
    end

endmodule

// ==== mem_game_fsm.sv ====
module mem_game_fsm (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 strobe,
    input  mem_pkg::button_t     button,
    input  logic                 mem_clear,
    input  logic                 mem_error,
    input  logic                 expired,
    output mem_pkg::game_state_t game_state,
    output mem_pkg::strike_t     strikes,
    output logic                 activate_rand,
    output logic                 mem_active
);
    import mem_pkg::*;

    game_state_t nxt_state;     // state after this edge
    logic        back_press;    // back pressed this cycle
    logic        last_strike;   // this error is the one that loses

    assign activate_rand = (game_state == st_menu) && strobe && (button == btn_select);
    assign mem_active    = (game_state == st_play);
    assign back_press    = strobe && (button == btn_back);
    assign last_strike   = mem_error && (strikes == strike_t'(max_strikes - 2'd1));

    always_comb begin
        nxt_state = game_state;
        case (game_state)
            st_menu: begin
                if (activate_rand) nxt_state = st_play;
            end
            st_play: begin
                if (mem_clear) nxt_state = st_won;                      // clearing beats the timer
                else if (last_strike || expired) nxt_state = st_lost;
            end
            st_lost, st_won: begin
                if (back_press) nxt_state = st_menu;
            end
            default: nxt_state = st_menu;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state <= st_menu;
            strikes    <= '0;
        end else begin
            game_state <= nxt_state;
            if (activate_rand) strikes <= '0;                   // fresh round
            else if (mem_error) strikes <= strikes + 2'd1;      // reaches 3 at most
        end
    end

    // detector gives one verdict per select
    a_one_verdict: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_clear && mem_error));

endmodule

// ==== mem_game_top.f ====
mem_pkg.sv
mem_rand_gen.sv
mem_cursor.sv
mem_round_timer.sv
mem_game_fsm.sv
mem_select_detector.sv
mem_game_top.sv
tb_mem_game_top.sv

// ==== mem_game_top.sv ====
module mem_game_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  strobe,
    input  mem_pkg::button_t      button,
    output mem_pkg::game_state_t  game_state,
    output mem_pkg::stage_t       stage,
    output mem_pkg::strike_t      strikes,
    output mem_pkg::time_t        time_left,
    output mem_pkg::pos_t         mem_pos,
    output mem_pkg::stage_view_t  view
);
    import mem_pkg::*;

    logic   activate_rand;  // one-cycle round start
    logic   mem_active;     // high while playing
    logic   mem_clear;      // fifth stage solved
    logic   mem_error;      // wrong select
    logic   expired;        // timer ran out
    round_t round;          // digits and labels of the round

    mem_game_fsm u_fsm (
        .clk, .nrst, .strobe, .button,
        .mem_clear, .mem_error, .expired,
        .game_state, .strikes, .activate_rand, .mem_active
    );

    mem_rand_gen u_rand (
        .clk, .nrst, .activate_rand, .round
    );

    mem_cursor u_cursor (
        .clk, .nrst, .activate_rand, .strobe, .button, .mem_pos
    );

    mem_round_timer u_timer (
        .clk, .nrst, .activate_rand, .mem_active, .time_left, .expired
    );

    mem_select_detector u_detect (
        .clk, .nrst, .activate_rand, .mem_active, .strobe, .button,
        .round, .mem_pos, .mem_error, .mem_clear, .stage
    );

    assign view = round.stages[stage];  // what the display shows now

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

    typedef logic [1:0]  pos_t;     // button position 0..3
    typedef logic [1:0]  digit_t;   // display digit, 0 shows "1"
    typedef logic [1:0]  label_t;   // button label, 0 shows "1"
    typedef logic [2:0]  stage_t;   // stage index 0..4
    typedef logic [5:0]  button_t;  // one-hot button code
    typedef logic [1:0]  strike_t;  // strikes so far
    typedef logic [11:0] time_t;    // cycles left in the round

    localparam button_t btn_select = 6'b000001;
    localparam button_t btn_up     = 6'b000010;
    localparam button_t btn_right  = 6'b000100;
    localparam button_t btn_down   = 6'b001000;
    localparam button_t btn_left   = 6'b010000;
    localparam button_t btn_back   = 6'b100000;
    localparam button_t btn_none   = 6'b000000;

    typedef enum logic [1:0] {
        st_menu = 2'd0,             // waiting for select
        st_play = 2'd1,             // round running
        st_lost = 2'd2,             // strikes or timer ran out
        st_won  = 2'd3              // all five stages cleared
    } game_state_t;

    localparam int      num_stages   = 5;
    localparam strike_t max_strikes  = 2'd3;
    localparam time_t   round_cycles = 12'd1000;
    localparam label_t  label_four   = 2'd3;        // label printed as "4"

    localparam logic [15:0] lfsr_seed = 16'hace1;   // any nonzero value works
    localparam logic [15:0] lfsr_taps = 16'hb400;   // x^16+x^14+x^13+x^11+1, maximal length

    // one stage as the player sees it
    typedef struct packed {
        digit_t       digit;        // big display digit
        label_t [3:0] labels;       // labels indexed by position
    } stage_view_t;

    // the whole round, drawn once at round start
    typedef struct packed {
        stage_view_t [num_stages-1:0] stages;
    } round_t;

endpackage

// ==== mem_rand_gen.sv ====
module mem_rand_gen (
    input  logic            clk,
    input  logic            nrst,
    input  logic            activate_rand,
    output mem_pkg::round_t round
);
    import mem_pkg::*;

    logic [15:0] lfsr;  // free-running galois lfsr
    logic [31:0] mix;   // widened word, five bits per stage are taken from it

    // digit from r[1:0], rotation from r[3:2], swap of pos 0/1 from r[4]
    function automatic stage_view_t make_view(input logic [4:0] r);
        stage_view_t v;
        label_t      tmp;
        v.digit = digit_t'(r[1:0]);
        for (int p = 0; p < 4; p++) begin
            v.labels[p] = label_t'(p + r[3:2]);     // rotated 0-1-2-3, wraps mod 4
        end
        if (r[4]) begin
            tmp         = v.labels[0];
            v.labels[0] = v.labels[1];
            v.labels[1] = tmp;
        end
        return v;
    endfunction

    // true when every stage carries four different labels
    function automatic logic round_distinct(input round_t r);
        logic [3:0] seen;
        logic       ok;
        ok = 1'b1;
        for (int s = 0; s < num_stages; s++) begin
            seen = '0;
            for (int p = 0; p < 4; p++) begin
                seen[r.stages[s].labels[p]] = 1'b1;
            end
            ok = ok & (&seen);
        end
        return ok;
    endfunction

    assign mix = {lfsr, lfsr ^ {lfsr[7:0], lfsr[15:8]}};  // byte-swapped copy fills the low half

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lfsr <= lfsr_seed;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ ({16{lfsr[0]}} & lfsr_taps);  // shift right, feed taps
        end
    end

    always_ff @(posedge clk) begin
        if (activate_rand) begin
            for (int s = 0; s < num_stages; s++) begin
                round.stages[s] <= make_view(mix[s*5 +: 5]);   // one 5-bit slice per stage
            end
        end
    end

    a_labels_distinct: assert property (@(posedge clk) disable iff (!nrst)
        activate_rand |=> round_distinct(round));

endmodule

// ==== mem_round_timer.sv ====
module mem_round_timer (
    input  logic           clk,
    input  logic           nrst,
    input  logic           activate_rand,
    input  logic           mem_active,
    output mem_pkg::time_t time_left,
    output logic           expired
);
    import mem_pkg::*;

    logic running;  // counting this cycle

    assign running = mem_active && (time_left != '0);

    // fires in the last counted cycle, so LOST is seen round_cycles after PLAY begins
    assign expired = mem_active && (time_left == time_t'(1));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            time_left <= '0;
        end else if (activate_rand) begin
            time_left <= round_cycles;          // full budget at round start
        end else if (running) begin
            time_left <= time_left - time_t'(1);
        end
    end

    // once expired has pulsed the counter must sit at zero
    a_expired_zero: assert property (@(posedge clk) disable iff (!nrst)
        expired |=> (time_left == '0));

endmodule

// ==== mem_select_detector.sv ====
module mem_select_detector (
    input  logic             clk,
    input  logic             nrst,
    input  logic             activate_rand,
    input  logic             mem_active,
    input  logic             strobe,
    input  mem_pkg::button_t button,
    input  mem_pkg::round_t  round,
    input  mem_pkg::pos_t    mem_pos,
    output logic             mem_error,
    output logic             mem_clear,
    output mem_pkg::stage_t  stage
);
    import mem_pkg::*;

    localparam stage_t last_stage = stage_t'(num_stages - 1);

    pos_t   right_pos [num_stages];     // correct position per stage
    label_t pressed   [num_stages-1];   // label under the correct position, stages 1 to 4
    stage_t nxt_stage;
    logic   select_hit;                 // select while the module is live

    // position that carries label l in view v
    function automatic pos_t pos_of(input stage_view_t v, input label_t l);
        pos_t p;
        p = '0;
        for (int i = 0; i < 4; i++) begin
            if (v.labels[i] == l) begin
                p = pos_t'(i);
            end
        end
        return p;
    endfunction

    always_comb begin
        // stage 1
        case (round.stages[0].digit)
            2'd0, 2'd1: right_pos[0] = 2'd1;                    // second position
            2'd2:       right_pos[0] = 2'd2;                    // third position
            default:    right_pos[0] = 2'd3;                    // fourth position
        endcase
        pressed[0] = round.stages[0].labels[right_pos[0]];

        // stage 2
        case (round.stages[1].digit)
            2'd0:    right_pos[1] = pos_of(round.stages[1], label_four);
            2'd2:    right_pos[1] = 2'd0;                       // first position
            default: right_pos[1] = right_pos[0];               // digits 2 and 4 repeat stage 1
        endcase
        pressed[1] = round.stages[1].labels[right_pos[1]];

        // stage 3
        case (round.stages[2].digit)
            2'd0:    right_pos[2] = pos_of(round.stages[2], pressed[1]);
            2'd1:    right_pos[2] = pos_of(round.stages[2], pressed[0]);
            2'd2:    right_pos[2] = 2'd2;                       // third position
            default: right_pos[2] = pos_of(round.stages[2], label_four);
        endcase
        pressed[2] = round.stages[2].labels[right_pos[2]];

        // stage 4
        case (round.stages[3].digit)
            2'd0:    right_pos[3] = right_pos[0];
            2'd1:    right_pos[3] = 2'd0;                       // first position
            default: right_pos[3] = right_pos[1];               // digits 3 and 4 follow stage 2
        endcase
        pressed[3] = round.stages[3].labels[right_pos[3]];

        // stage 5, always by label
        case (round.stages[4].digit)
            2'd0:    right_pos[4] = pos_of(round.stages[4], pressed[0]);
            2'd1:    right_pos[4] = pos_of(round.stages[4], pressed[1]);
            2'd2:    right_pos[4] = pos_of(round.stages[4], pressed[3]);
            default: right_pos[4] = pos_of(round.stages[4], pressed[2]);
        endcase
    end

    assign select_hit = mem_active && strobe && (button == btn_select);

    always_comb begin
        mem_clear = 1'b0;
        mem_error = 1'b0;
        nxt_stage = stage;
        if (select_hit) begin
            if (mem_pos == right_pos[stage]) begin
                if (stage == last_stage) mem_clear = 1'b1;      // module solved
                else nxt_stage = stage + 3'd1;
            end else begin
                mem_error = 1'b1;                               // wrong button, stage holds
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            stage <= '0;
        end else if (activate_rand) begin
            stage <= '0;
        end else begin
            stage <= nxt_stage;
        end
    end

    a_stage_range: assert property (@(posedge clk) disable iff (!nrst)
        stage <= last_stage);

endmodule

// ==== tb_mem_game_top.sv ====
module tb_mem_game_top;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int timeout_limit = 6 * int'(round_cycles) + 2000;  // cycles before giving up

    logic        clk = 1'b0;
    logic        nrst;
    logic        strobe;
    button_t     button;
    game_state_t game_state;
    stage_t      stage;
    strike_t     strikes;
    time_t       time_left;
    pos_t        mem_pos;
    stage_view_t view;

    integer            seed = 32'h4e1efa30;     // fixed seed for $random
    int                cycles = 0;              // rising edges since time zero
    int                play_start;              // cycle count when PLAY began
    int                err_count = 0;
    int                errs_at_start = 0;       // err_count when the current test began
    int                pass_count = 0;
    int                fail_count = 0;
    stage_view_t [4:0] views;                   // view seen at each stage of the round

    mem_game_top i_dut (
        .clk, .nrst, .strobe, .button,
        .game_state, .stage, .strikes, .time_left, .mem_pos, .view
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // position in view v that carries label l
    function automatic pos_t find_label(input stage_view_t v, input label_t l);
        pos_t p;
        p = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (v.labels[i] == l) p = pos_t'(i);
        end
        return p;
    endfunction

    // one bit per label value present in view v, all four set when the labels are distinct
    function automatic logic [3:0] label_set(input stage_view_t v);
        logic [3:0] seen;
        seen = 4'h0;
        for (int i = 0; i < 4; i++) begin
            seen[v.labels[i]] = 1'b1;
        end
        return seen;
    endfunction

    // answer for stage s, derived from the stage rules table (digit 0 shows "1")
    function automatic pos_t expected_pos(input int s, input stage_view_t [4:0] v);
        pos_t   p [5];  // answer per stage
        label_t l [5];  // label under that answer
        p[0] = (v[0].digit == 2'd2) ? 2'd2 : (v[0].digit == 2'd3) ? 2'd3 : 2'd1;
        l[0] = v[0].labels[p[0]];
        p[1] = (v[1].digit == 2'd0) ? find_label(v[1], 2'd3)   // label 4
             : (v[1].digit == 2'd2) ? 2'd0 : p[0];
        l[1] = v[1].labels[p[1]];
        case (v[2].digit)
            2'd0:    p[2] = find_label(v[2], l[1]);
            2'd1:    p[2] = find_label(v[2], l[0]);
            2'd2:    p[2] = 2'd2;
            default: p[2] = find_label(v[2], 2'd3);
        endcase
        l[2] = v[2].labels[p[2]];
        p[3] = (v[3].digit == 2'd0) ? p[0] : (v[3].digit == 2'd1) ? 2'd0 : p[1];
        l[3] = v[3].labels[p[3]];
        case (v[4].digit)   // last stage goes by earlier labels only
            2'd0:    p[4] = find_label(v[4], l[0]);
            2'd1:    p[4] = find_label(v[4], l[1]);
            2'd2:    p[4] = find_label(v[4], l[3]);
            default: p[4] = find_label(v[4], l[2]);
        endcase
        return p[s];
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == errs_at_start) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, err_count - errs_at_start);
        end
        errs_at_start = err_count;
    endtask

    // one-cycle strobe, returns at the falling edge after the DUT took it
    task automatic press(input button_t b);
        @(posedge clk);
        strobe <= 1'b1;
        button <= b;
        @(posedge clk);
        strobe <= 1'b0;
        button <= btn_none;
        @(negedge clk);
    endtask

    task automatic steer_to(input pos_t target);
        logic go_right;
        pos_t steps;
        go_right = ($random(seed) % 2) != 0;                    // either way round works
        steps = go_right ? target - mem_pos : mem_pos - target;
        repeat (steps) press(go_right ? btn_right : btn_left);
        check_val("mem_pos", mem_pos, target);
    endtask

    task automatic start_round();
        press(btn_select);
        play_start = cycles;                                    // edge that entered PLAY
        check_val("game_state", game_state, st_play);
        check_val("time_left", time_left, round_cycles);
        check_val("stage", stage, 0);
        check_val("strikes", strikes, 0);
        check_val("mem_pos", mem_pos, 0);
    endtask

    task automatic restart_round();
        press(btn_back);
        check_val("game_state", game_state, st_menu);
        start_round();
    endtask

    task automatic play_correct_round();
        for (int s = 0; s < num_stages; s++) begin
            views[s] = view;                                    // digit and labels of stage s
            check_val("view.labels", label_set(view), 4'hf);    // four different labels
            steer_to(expected_pos(s, views));
            press(btn_select);
            if (s < num_stages - 1) begin
                check_val("stage", stage, s + 1);
            end else begin
                check_val("game_state", game_state, st_won);
                check_val("strikes", strikes, 0);
            end
        end
    endtask

    initial begin
        pos_t model_pos;    // cursor as the testbench expects it
        pos_t target;
        pos_t wrong;
        int   r;
        nrst = 1'b0;
        strobe = 1'b0;
        button = btn_none;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_val("game_state", game_state, st_menu);
        check_val("stage", stage, 0);
        check_val("strikes", strikes, 0);
        check_val("time_left", time_left, 0);
        start_round();
        end_test("reset and start");
        model_pos = 2'd0;   // a new round starts at the leftmost button
        repeat (24) begin
            r = $unsigned($random(seed)) % 3;
            press(r == 0 ? btn_right : r == 1 ? btn_left : btn_up);    // up leaves the cursor
            model_pos = (r == 0) ? model_pos + 2'd1 : (r == 1) ? model_pos - 2'd1 : model_pos;
            check_val("mem_pos", mem_pos, model_pos);
        end
        end_test("cursor moves");
        repeat (3) begin
            play_correct_round();
            restart_round();
        end
        play_correct_round();
        end_test("correct rounds");
        restart_round();
        end_test("back from won");
        views[0] = view;
        steer_to(expected_pos(0, views));
        press(btn_select);
        check_val("stage", stage, 1);
        views[1] = view;
        target = expected_pos(1, views);
        for (int w = 0; w < 3; w++) begin
            wrong = target + pos_t'(1 + $unsigned($random(seed)) % 3);  // never the answer
            steer_to(wrong);
            press(btn_select);
            check_val("stage", stage, 1);
            check_val("strikes", strikes, w + 1);
            check_val("game_state", game_state, (w < 2) ? st_play : st_lost);
        end
        end_test("wrong presses");
        restart_round();
        end_test("back from lost");
        while (game_state != st_lost) @(negedge clk);           // no presses, timer runs out
        check_val("cycles to lost", cycles - play_start, round_cycles);
        check_val("time_left", time_left, 0);
        end_test("round timeout");
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
